//--- pmu_settings.svh
`ifndef PMU_SETTINGS_SVH
`define PMU_SETTINGS_SVH

// --------------------
// Address geometry
// --------------------
`define PMU_PAGE_W      10                              // Page number bits
`define PMU_OFFSET_W    10                              // Word offset within a page
`define PMU_ADDR_W      (`PMU_PAGE_W + `PMU_OFFSET_W)   // Virtual or physical address
`define PMU_PAGES       1024                            // Map and status entries

// --------------------
// Queues and credits
// --------------------
`define PMU_CMD_DEPTH   4                               // Also the host's initial credits
`define PMU_RSP_DEPTH   4                               // Also the initial response credits

// Counter wide enough for 0..PMU_RSP_DEPTH
`define PMU_RSP_CNT_W   ($clog2(`PMU_RSP_DEPTH + 1))

`endif

//--- pmu_pkg.sv
`default_nettype none

`include "pmu_settings.svh"

package pmu_pkg;

    typedef logic [`PMU_PAGE_W-1:0] page_t;             // Page number

    typedef struct packed {
        page_t                    page;                 // Upper bits, translated
        logic [`PMU_OFFSET_W-1:0] offset;               // Passed through untouched
    } vaddr_t;

    // Bus opcodes, only the write class matters here
    typedef enum logic [3:0] {
        NOP   = 4'd0,
        CCWR  = 4'd2,                                   // Instruction cache write
        DCWR  = 4'd4,                                   // Operand cache write
        DWR   = 4'd10,                                  // Result write
        RDMWR = 4'd11,                                  // Read-modify-write
        BTRWR = 4'd12                                   // Block transfer write
    } arb_op_t;

    typedef enum logic [2:0] {
        MAP_WR, MAP_RD,                                 // Page map access
        XLATE,                                          // Translate and mark used/dirty
        ACC_WR, ACC_RD,                                 // Used and dirty bits
        REP_WR, REP_RD,                                 // Reprioritize bit
        FILL                                            // Set reprio on every page
    } cmd_op_t;

    // Per-page status, ACC_WR data[1:0] = {dirty, used}, REP_WR data[2] = reprio
    typedef struct packed {
        logic reprio;
        logic dirty;
        logic used;
    } pg_bits_t;

    typedef struct packed {
        cmd_op_t op;
        arb_op_t arb;                                   // Bus opcode for XLATE
        vaddr_t  addr;
        page_t   data;                                  // Map entry or bit values
    } pmu_cmd_t;

    // ACC_RD returns {dirty, used} in data[1:0], REP_RD returns reprio in data[0]
    typedef struct packed {
        cmd_op_t                op;                     // Echo of the command opcode
        logic [`PMU_ADDR_W-1:0] data;
    } pmu_rsp_t;

endpackage

`default_nettype wire

//--- credit_fifo.sv
`default_nettype none
`timescale 1ns/1ns

module credit_fifo #(
    parameter type T_ITEM = logic [7:0],                // Payload type
    parameter int  DEPTH  = 4
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         i_push,         // Write i_data
    input  wire T_ITEM                  i_data,
    input  wire                         i_pop,          // Drop head entry
    output T_ITEM                       o_data,         // Head entry, valid when not empty
    output logic                        o_empty,
    output logic [$clog2(DEPTH+1)-1:0]  o_free          // Free slots
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T_ITEM            mem [DEPTH];                      // Storage, no reset
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;                            // Occupancy

    // Wrap at DEPTH, not at the pointer width
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (i_push)
            mem[wr_ptr] <= i_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push)
                wr_ptr <= ptr_next(wr_ptr);
            if (i_pop)
                rd_ptr <= ptr_next(rd_ptr);
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;        // Push only
                2'b01:   count <= count - 1'b1;        // Pop only
                default: count <= count;                // Both or neither
            endcase
        end
    end

    assign o_data  = mem[rd_ptr];                       // Show-ahead read
    assign o_empty = (count == '0);
    assign o_free  = CNT_W'(DEPTH) - count;

endmodule

`default_nettype wire

//--- pmu_page_map.sv
`default_nettype none
`timescale 1ns/1ns

`include "pmu_settings.svh"

module pmu_page_map (
    input  wire                     clk,
    input  wire                     i_valid,            // Command entering map stage
    input  wire pmu_pkg::pmu_cmd_t  i_cmd,
    input  wire                     i_no_paging,        // Bypass translation
    output pmu_pkg::page_t          o_ppage,            // Translated page, next cycle
    output pmu_pkg::page_t          o_entry             // Raw map entry, next cycle
);

    import pmu_pkg::*;

    page_t map_mem [`PMU_PAGES];                        // Virtual to physical page
    page_t vpage;
    page_t entry_rd;

    assign vpage    = i_cmd.addr.page;
    assign entry_rd = map_mem[vpage];

    // --------------------
    // Map write
    // --------------------
    always_ff @(posedge clk) begin
        if (i_valid && i_cmd.op == MAP_WR)
            map_mem[vpage] <= i_cmd.data;               // Only the page number is kept
    end

    // --------------------
    // Map stage register
    // --------------------
    always_ff @(posedge clk) begin
        o_entry <= entry_rd;                            // Old value on a same-cycle write
        o_ppage <= i_no_paging ? vpage : entry_rd;      // Identity map when paging is off
    end

endmodule

`default_nettype wire

//--- pmu_page_status.sv
`default_nettype none
`timescale 1ns/1ns

`include "pmu_settings.svh"

module pmu_page_status (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     i_valid,            // Command in status stage
    input  wire pmu_pkg::pmu_cmd_t  i_cmd,
    input  wire pmu_pkg::page_t     i_ppage,            // From the map stage
    output pmu_pkg::pg_bits_t       o_bits,             // Bits of the selected page
    output logic                    o_fill_busy         // Reprio fill running
);

    import pmu_pkg::*;

    logic  used_mem   [`PMU_PAGES];                     // Page referenced
    logic  dirty_mem  [`PMU_PAGES];                     // Page modified
    logic  reprio_mem [`PMU_PAGES];                     // Reprioritize request
    page_t fill_cnt;                                    // Next page to fill
    page_t sel_page;
    logic  wr_class;                                    // Bus opcode writes memory

    // XLATE works on the physical page, everything else on the command page
    assign sel_page = (i_cmd.op == XLATE) ? i_ppage : i_cmd.addr.page;

    always_comb begin
        case (i_cmd.arb)
            CCWR, DCWR, DWR, RDMWR, BTRWR: wr_class = 1'b1;
            default:                       wr_class = 1'b0;
        endcase
    end

    // --------------------
    // Used and dirty
    // --------------------
    always_ff @(posedge clk) begin
        if (i_valid) begin
            case (i_cmd.op)
                XLATE: begin
                    used_mem[sel_page] <= 1'b1;         // Any access marks used
                    if (wr_class)
                        dirty_mem[sel_page] <= 1'b1;
                end
                ACC_WR: begin
                    used_mem[sel_page]  <= i_cmd.data[0];
                    dirty_mem[sel_page] <= i_cmd.data[1];
                end
                default: ;
            endcase
        end
    end

    // --------------------
    // Reprio and fill
    // --------------------
    always_ff @(posedge clk) begin
        if (o_fill_busy)
            reprio_mem[fill_cnt] <= 1'b1;               // One page per cycle
        else if (i_valid && i_cmd.op == REP_WR)
            reprio_mem[sel_page] <= i_cmd.data[2];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_fill_busy <= 1'b0;
            fill_cnt    <= '0;
        end else if (o_fill_busy) begin
            if (fill_cnt == page_t'(`PMU_PAGES - 1))
                o_fill_busy <= 1'b0;                    // Last page written
            fill_cnt <= fill_cnt + 1'b1;
        end else if (i_valid && i_cmd.op == FILL) begin
            o_fill_busy <= 1'b1;
            fill_cnt    <= '0;                          // Always from page 0
        end
    end

    // Read for the response, before this cycle's update lands
    always_ff @(posedge clk) begin
        o_bits.reprio <= reprio_mem[sel_page];
        o_bits.dirty  <= dirty_mem[sel_page];
        o_bits.used   <= used_mem[sel_page];
    end

endmodule

`default_nettype wire

//--- pmu_pipe_ctrl.sv
`default_nettype none
`timescale 1ns/1ns

`include "pmu_settings.svh"

module pmu_pipe_ctrl (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         i_cmd_empty,
    input  wire pmu_pkg::pmu_cmd_t      i_cmd,          // Command FIFO head
    output logic                        o_cmd_pop,      // Also the command credit
    output logic                        o_s1_valid,     // Into map stage
    output pmu_pkg::pmu_cmd_t           o_s1_cmd,
    output logic                        o_s2_valid,     // Into status stage
    output pmu_pkg::pmu_cmd_t           o_s2_cmd,
    input  wire pmu_pkg::page_t         i_ppage,
    input  wire pmu_pkg::page_t         i_entry,
    input  wire pmu_pkg::pg_bits_t      i_bits,
    input  wire                         i_fill_busy,
    input  wire [`PMU_RSP_CNT_W-1:0]    i_rsp_free,
    output logic                        o_rsp_push,
    output pmu_pkg::pmu_rsp_t           o_rsp,
    input  wire                         i_rsp_empty,
    output logic                        o_rsp_pop,      // Also o_rsp_valid
    input  wire                         i_rsp_credit
);

    import pmu_pkg::*;

    localparam int CNT_W = `PMU_RSP_CNT_W;

    logic [CNT_W-1:0] inflight;                         // Popped, response not pushed
    logic [CNT_W-1:0] rsp_credits;                      // Host-side response slots
    logic             fill_pend;                        // FILL popped, not answered
    logic             r_valid;                          // Response stage
    pmu_cmd_t         r_cmd;
    page_t            r_ppage;
    page_t            r_entry;
    logic             r_hold;

    // --------------------
    // Issue
    // --------------------
    // Pop only when a response slot is reserved for it
    assign o_cmd_pop  = !i_cmd_empty && !fill_pend && (i_rsp_free > inflight);
    assign o_s1_valid = o_cmd_pop;
    assign o_s1_cmd   = i_cmd;

    always_ff @(posedge clk) begin
        if (reset) begin
            o_s2_valid <= 1'b0;
            fill_pend  <= 1'b0;
        end else begin
            o_s2_valid <= o_cmd_pop;
            if (o_cmd_pop && i_cmd.op == FILL)
                fill_pend <= 1'b1;
            else if (o_rsp_push && r_cmd.op == FILL)
                fill_pend <= 1'b0;                      // Pops resume after the fill
        end
    end

    always_ff @(posedge clk) begin
        o_s2_cmd <= i_cmd;
    end

    // --------------------
    // Response stage
    // --------------------
    assign r_hold     = r_valid && (r_cmd.op == FILL) && i_fill_busy;
    assign o_rsp_push = r_valid && !r_hold;

    always_ff @(posedge clk) begin
        if (reset)
            r_valid <= 1'b0;
        else if (!r_hold)
            r_valid <= o_s2_valid;
    end

    always_ff @(posedge clk) begin
        if (!r_hold) begin
            r_cmd   <= o_s2_cmd;
            r_ppage <= i_ppage;                         // Map outputs move on next cycle
            r_entry <= i_entry;
        end
    end

    always_comb begin
        o_rsp.op   = r_cmd.op;
        o_rsp.data = '0;
        case (r_cmd.op)
            XLATE:   o_rsp.data = {r_ppage, r_cmd.addr.offset};
            MAP_RD:  o_rsp.data[`PMU_PAGE_W-1:0] = r_entry;
            ACC_RD:  o_rsp.data[1:0] = {i_bits.dirty, i_bits.used};
            REP_RD:  o_rsp.data[0] = i_bits.reprio;
            default: ;                                  // Writes answer with zero
        endcase
    end

    // --------------------
    // Credits
    // --------------------
    assign o_rsp_pop = !i_rsp_empty && (rsp_credits != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            inflight    <= '0;
            rsp_credits <= CNT_W'(`PMU_RSP_DEPTH);
        end else begin
            case ({o_cmd_pop, o_rsp_push})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: inflight <= inflight;
            endcase
            case ({i_rsp_credit, o_rsp_pop})
                2'b10:   rsp_credits <= rsp_credits + 1'b1;
                2'b01:   rsp_credits <= rsp_credits - 1'b1;
                default: rsp_credits <= rsp_credits;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- pmu_top.sv
`default_nettype none
`timescale 1ns/1ns

`include "pmu_settings.svh"

module pmu_top (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     i_cmd_valid,        // One command per credit
    input  wire pmu_pkg::pmu_cmd_t  i_cmd,
    output logic                    o_cmd_credit,       // Command FIFO pop
    input  wire                     i_no_paging,
    output logic                    o_rsp_valid,        // Response FIFO pop
    output pmu_pkg::pmu_rsp_t       o_rsp,
    input  wire                     i_rsp_credit
);

    import pmu_pkg::*;

    pmu_cmd_t                   cmd_head;
    logic                       cmd_empty;
    logic                       s1_valid;
    pmu_cmd_t                   s1_cmd;
    logic                       s2_valid;
    pmu_cmd_t                   s2_cmd;
    page_t                      ppage;
    page_t                      entry;
    pg_bits_t                   bits;
    logic                       fill_busy;
    logic [`PMU_RSP_CNT_W-1:0]  rsp_free;
    logic                       rsp_push;
    pmu_rsp_t                   rsp_in;
    logic                       rsp_empty;

    // --------------------
    // Queues
    // --------------------
    credit_fifo #(.T_ITEM(pmu_cmd_t), .DEPTH(`PMU_CMD_DEPTH)) u_cmd_fifo (
        .clk(clk), .reset(reset),
        .i_push(i_cmd_valid), .i_data(i_cmd),
        .i_pop(o_cmd_credit), .o_data(cmd_head),
        .o_empty(cmd_empty), .o_free()                  // Credits bound the fill level
    );

    credit_fifo #(.T_ITEM(pmu_rsp_t), .DEPTH(`PMU_RSP_DEPTH)) u_rsp_fifo (
        .clk(clk), .reset(reset),
        .i_push(rsp_push), .i_data(rsp_in),
        .i_pop(o_rsp_valid), .o_data(o_rsp),
        .o_empty(rsp_empty), .o_free(rsp_free)
    );

    // --------------------
    // Pipeline
    // --------------------
    pmu_page_map u_map (
        .clk(clk), .i_valid(s1_valid), .i_cmd(s1_cmd), .i_no_paging(i_no_paging),
        .o_ppage(ppage), .o_entry(entry)
    );

    pmu_page_status u_status (
        .clk(clk), .reset(reset), .i_valid(s2_valid), .i_cmd(s2_cmd), .i_ppage(ppage),
        .o_bits(bits), .o_fill_busy(fill_busy)
    );

    pmu_pipe_ctrl u_ctrl (
        .clk(clk), .reset(reset),
        .i_cmd_empty(cmd_empty), .i_cmd(cmd_head), .o_cmd_pop(o_cmd_credit),
        .o_s1_valid(s1_valid), .o_s1_cmd(s1_cmd), .o_s2_valid(s2_valid), .o_s2_cmd(s2_cmd),
        .i_ppage(ppage), .i_entry(entry), .i_bits(bits), .i_fill_busy(fill_busy),
        .i_rsp_free(rsp_free), .o_rsp_push(rsp_push), .o_rsp(rsp_in),
        .i_rsp_empty(rsp_empty), .o_rsp_pop(o_rsp_valid), .i_rsp_credit(i_rsp_credit)
    );

endmodule

`default_nettype wire

//--- pmu_sva.sv
`default_nettype none
`timescale 1ns/1ns

`include "pmu_settings.svh"

module pmu_sva (
    input wire clk,
    input wire reset,
    input wire i_cmd_valid,                             // Host command into the FIFO
    input wire i_cmd_credit,                            // Credit back to the host
    input wire i_rsp_valid,                             // Response FIFO pop
    input wire i_rsp_credit,                            // Credit from the host
    input wire i_rsp_push                               // Response FIFO write
);

    logic [3:0] host_credits;                           // Credits the host holds
    logic [3:0] rsp_credits;                            // Response slots at the host
    logic [3:0] cmd_occ;                                // Command FIFO fill level
    logic [3:0] rsp_occ;                                // Response FIFO fill level

    always_ff @(posedge clk) begin
        if (reset) begin
            host_credits <= 4'(`PMU_CMD_DEPTH);
            rsp_credits  <= 4'(`PMU_RSP_DEPTH);
            cmd_occ      <= '0;
            rsp_occ      <= '0;
        end else begin
            host_credits <= host_credits + 4'(i_cmd_credit) - 4'(i_cmd_valid);
            rsp_credits  <= rsp_credits + 4'(i_rsp_credit) - 4'(i_rsp_valid);
            cmd_occ      <= cmd_occ + 4'(i_cmd_valid) - 4'(i_cmd_credit);
            rsp_occ      <= rsp_occ + 4'(i_rsp_push) - 4'(i_rsp_valid);
        end
    end

    // --------------------
    // Channel rules
    // --------------------
    // A credit returned in the same cycle may be spent at once
    a_cmd_credit: assert property (@(posedge clk) disable iff (reset)
        i_cmd_valid |-> (host_credits != '0 || i_cmd_credit))
        else $error("Command sent while the host held no command credit");

    a_rsp_credit: assert property (@(posedge clk) disable iff (reset)
        i_rsp_valid |-> (rsp_credits != '0))
        else $error("Response sent while no response credit was available");

    a_cmd_full: assert property (@(posedge clk) disable iff (reset)
        (i_cmd_valid && !i_cmd_credit) |-> (cmd_occ < 4'(`PMU_CMD_DEPTH)))
        else $error("Command FIFO written while full");

    a_rsp_full: assert property (@(posedge clk) disable iff (reset)
        (i_rsp_push && !i_rsp_valid) |-> (rsp_occ < 4'(`PMU_RSP_DEPTH)))
        else $error("Response FIFO written while full");

endmodule

`default_nettype wire

//--- pmu_tb.sv
`default_nettype none
`timescale 1ns/1ns

`include "pmu_settings.svh"

module pmu_tb;

    import pmu_pkg::*;

    // 1024-cycle fill plus about 300 commands of a few cycles each
    localparam int TIMEOUT = 6000;

    logic     clk = 1'b0;
    logic     reset;
    logic     i_cmd_valid = 1'b0;
    pmu_cmd_t i_cmd = '0;
    logic     o_cmd_credit;
    logic     i_no_paging;
    logic     o_rsp_valid;
    pmu_rsp_t o_rsp;
    logic     i_rsp_credit = 1'b0;

    // --------------------
    // Host state
    // --------------------
    logic        active = 1'b0;                         // Driver runs after reset
    logic        hold_credits = 1'b0;                   // Withhold response credits
    int          cmd_credits = `PMU_CMD_DEPTH;
    int          owed = 0;                              // Responses not yet credited
    int          rsp_seen = 0;
    int          cred_seen = 0;                         // Command credits received
    int          cycles = 0;
    logic [31:0] lcg_state = 32'd98320;
    string       cur_test = "reset";
    pmu_cmd_t    send_q [$];                            // Commands waiting for credit
    pmu_rsp_t    exp_q [$];                             // Responses in command order
    pmu_rsp_t    exp_rsp;

    // Reference model
    page_t ref_map    [`PMU_PAGES];
    logic  ref_used   [`PMU_PAGES];
    logic  ref_dirty  [`PMU_PAGES];
    logic  ref_reprio [`PMU_PAGES];
    page_t mapped [$];                                  // Pages with a known entry

    pmu_top u_dut (
        .clk(clk), .reset(reset),
        .i_cmd_valid(i_cmd_valid), .i_cmd(i_cmd), .o_cmd_credit(o_cmd_credit),
        .i_no_paging(i_no_paging),
        .o_rsp_valid(o_rsp_valid), .o_rsp(o_rsp), .i_rsp_credit(i_rsp_credit)
    );

    bind pmu_top pmu_sva u_sva (
        .clk(clk), .reset(reset), .i_cmd_valid(i_cmd_valid), .i_cmd_credit(o_cmd_credit),
        .i_rsp_valid(o_rsp_valid), .i_rsp_credit(i_rsp_credit), .i_rsp_push(rsp_push)
    );

    always #50 clk = ~clk;                              // 100 ns period

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    // --------------------
    // Random numbers
    // --------------------
    function automatic logic [31:0] rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic page_t rand_page();
        logic [31:0] r;
        r = rand_next();
        return r[25:16];                                // Upper LCG bits spread better
    endfunction

    function automatic logic [`PMU_OFFSET_W-1:0] rand_offset();
        logic [31:0] r;
        r = rand_next();
        return r[21:12];
    endfunction

    function automatic logic [3:0] rand_arb();
        logic [31:0] r;
        r = rand_next();
        return r[27:24];
    endfunction

    // Bus opcodes that write memory mark the page dirty
    function automatic logic is_write_op(input logic [3:0] arb);
        return (arb == 4'd2) || (arb == 4'd4) || (arb == 4'd10) ||
               (arb == 4'd11) || (arb == 4'd12);
    endfunction

    // --------------------
    // Command queue and model
    // --------------------
    task automatic queue_cmd(input cmd_op_t op, input logic [3:0] arb, input page_t page,
                             input logic [`PMU_OFFSET_W-1:0] offset, input page_t data);
        pmu_cmd_t c;
        pmu_rsp_t r;
        page_t    phys;
        c.op          = op;
        c.arb         = arb_op_t'(arb);
        c.addr.page   = page;
        c.addr.offset = offset;
        c.data        = data;
        r.op          = op;
        r.data        = '0;                             // Writes answer with zero
        case (op)
            MAP_WR: ref_map[page] = data;
            MAP_RD: r.data = 20'(ref_map[page]);
            XLATE: begin
                phys = i_no_paging ? page : ref_map[page];
                r.data = {phys, offset};
                ref_used[phys] = 1'b1;
                if (is_write_op(arb))
                    ref_dirty[phys] = 1'b1;
            end
            ACC_WR: begin
                ref_used[page]  = data[0];
                ref_dirty[page] = data[1];
            end
            ACC_RD: r.data[1:0] = {ref_dirty[page], ref_used[page]};
            REP_WR: ref_reprio[page] = data[2];
            REP_RD: r.data[0] = ref_reprio[page];
            FILL: begin
                for (int p = 0; p < `PMU_PAGES; p++)
                    ref_reprio[p] = 1'b1;
            end
            default: ;
        endcase
        send_q.push_back(c);
        exp_q.push_back(r);
    endtask

    task automatic wait_idle();
        while (send_q.size() != 0 || exp_q.size() != 0 || owed != 0)
            @(posedge clk);
    endtask

    task automatic set_no_paging(input logic v);
        @(negedge clk);
        i_no_paging = v;
        @(posedge clk);                                 // Tasks resume on the rising edge
    endtask

    // --------------------
    // Host driver and scoreboard
    // --------------------
    always @(negedge clk) begin
        if (active) begin
            if (o_cmd_credit) begin
                cmd_credits++;
                cred_seen++;
            end
            if (o_rsp_valid) begin
                assert (exp_q.size() != 0)
                    else abort_run($sformatf("Response in %s with no command outstanding",
                                             cur_test));
                exp_rsp = exp_q.pop_front();
                assert (o_rsp == exp_rsp)
                    else abort_run($sformatf("Error: %s expected %h actual %h",
                                             cur_test, exp_rsp, o_rsp));
                owed++;
                rsp_seen++;
            end
            i_rsp_credit = 1'b0;                        // One credit back per cycle
            if (!hold_credits && owed != 0) begin
                i_rsp_credit = 1'b1;
                owed--;
            end
            i_cmd_valid = 1'b0;
            if (send_q.size() != 0 && cmd_credits != 0) begin
                i_cmd       = send_q.pop_front();
                i_cmd_valid = 1'b1;
                cmd_credits--;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT)
            abort_run($sformatf("Timeout after %0d cycles in %s", cycles, cur_test));
    end

    // --------------------
    // Tests
    // --------------------
    task automatic test_map();
        page_t vp [16];
        cur_test = "test_map";
        for (int i = 0; i < 16; i++) begin
            vp[i] = rand_page();
            queue_cmd(MAP_WR, 4'd0, vp[i], '0, rand_page());
            mapped.push_back(vp[i]);
        end
        for (int i = 0; i < 16; i++)
            queue_cmd(MAP_RD, 4'd0, vp[i], '0, '0);
        wait_idle();
    endtask

    task automatic test_xlate();
        cur_test = "test_xlate";
        set_no_paging(1'b0);
        foreach (mapped[i])
            queue_cmd(XLATE, rand_arb(), mapped[i], rand_offset(), '0);
        wait_idle();
        set_no_paging(1'b1);                            // Address comes back unchanged
        for (int i = 0; i < 16; i++)
            queue_cmd(XLATE, rand_arb(), rand_page(), rand_offset(), '0);
        wait_idle();
        set_no_paging(1'b0);
    endtask

    task automatic test_access();
        page_t vp [8];
        page_t pp [8];
        cur_test = "test_access";
        for (int i = 0; i < 8; i++) begin
            vp[i] = rand_page();
            pp[i] = rand_page();
            queue_cmd(MAP_WR, 4'd0, vp[i], '0, pp[i]);
            queue_cmd(ACC_WR, 4'd0, pp[i], '0, '0);    // Clear used and dirty
        end
        for (int i = 0; i < 16; i++)
            queue_cmd(XLATE, rand_arb(), vp[i % 8], rand_offset(), '0);
        for (int i = 0; i < 8; i++)
            queue_cmd(ACC_RD, 4'd0, pp[i], '0, '0);
        for (int i = 0; i < 4; i++) begin              // Direct writes of each pattern
            queue_cmd(ACC_WR, 4'd0, pp[i], '0, page_t'(i));
            queue_cmd(ACC_RD, 4'd0, pp[i], '0, '0);
        end
        wait_idle();
    endtask

    task automatic test_fill();
        page_t pg [8];
        cur_test = "test_fill";
        for (int i = 0; i < 8; i++) begin
            pg[i] = rand_page();
            queue_cmd(REP_WR, 4'd0, pg[i], '0, page_t'(4));  // Set reprio so the clear shows
            queue_cmd(REP_RD, 4'd0, pg[i], '0, '0);
        end
        for (int i = 0; i < 8; i++)
            queue_cmd(REP_WR, 4'd0, pg[i], '0, '0);
        for (int i = 0; i < 8; i++)
            queue_cmd(REP_RD, 4'd0, pg[i], '0, '0);
        queue_cmd(FILL, 4'd0, '0, '0, '0);             // Its response comes before the reads
        for (int i = 0; i < 8; i++)
            queue_cmd(REP_RD, 4'd0, pg[i], '0, '0);
        queue_cmd(REP_RD, 4'd0, '0, '0, '0);            // Both ends of the page range
        queue_cmd(REP_RD, 4'd0, page_t'(`PMU_PAGES - 1), '0, '0);
        wait_idle();
    endtask

    task automatic test_credit();
        logic [31:0] r;
        int          seen0;
        int          cred0;
        cur_test = "test_credit";
        hold_credits = 1'b1;
        seen0 = rsp_seen;
        for (int i = 0; i < 16; i++) begin
            r = rand_next();
            case (r[17:16])
                2'd0:    queue_cmd(MAP_RD, 4'd0, mapped[r[3:0]], '0, '0);
                2'd1:    queue_cmd(REP_RD, 4'd0, rand_page(), '0, '0);
                default: queue_cmd(XLATE, rand_arb(), mapped[r[3:0]], rand_offset(), '0);
            endcase
        end
        repeat (30) @(posedge clk);                     // Let the pipeline back up
        cred0 = cred_seen;
        repeat (20) @(posedge clk);
        assert (rsp_seen - seen0 <= `PMU_RSP_DEPTH)
            else abort_run($sformatf("Error: %s expected at most %0d responses actual %0d",
                                     cur_test, `PMU_RSP_DEPTH, rsp_seen - seen0));
        assert (cred_seen == cred0)
            else abort_run($sformatf("Error: %s expected 0 credits while stalled actual %0d",
                                     cur_test, cred_seen - cred0));
        hold_credits = 1'b0;                            // Remaining responses drain in order
        wait_idle();
        assert (cmd_credits == `PMU_CMD_DEPTH)
            else abort_run($sformatf("Error: %s expected %0d command credits actual %0d",
                                     cur_test, `PMU_CMD_DEPTH, cmd_credits));
    endtask

    initial begin
        reset       = 1'b1;
        i_no_paging = 1'b0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(posedge clk);
        active = 1'b1;
        test_map();
        test_xlate();
        test_access();
        test_fill();
        test_credit();
        if (exp_q.size() == 0 && cmd_credits == `PMU_CMD_DEPTH) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run("Run ended with responses or command credits outstanding");
        end
    end

endmodule

`default_nettype wire

//--- pmu.f
+incdir+.
pmu_pkg.sv
credit_fifo.sv
pmu_page_map.sv
pmu_page_status.sv
pmu_pipe_ctrl.sv
pmu_top.sv
pmu_sva.sv
pmu_tb.sv

//--- run_pmu.sh
#!/bin/sh
# Build and run the PMU testbench with Verilator
set -e

verilator --binary --timing --assert -Wno-fatal --top-module pmu_tb -f pmu.f -o Vpmu_tb

status=0
./obj_dir/Vpmu_tb > run.log 2>&1 || status=$?
cat run.log

if grep -q "STATUS: FAIL" run.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
echo "Simulation finished without failures"
